// ==== Bender.yml ====
package:
  name: scope_trigger

sources:
  - hdl/scope_pkg.sv
  - hdl/trig_cfg_if.sv
  - hdl/scope_regs.sv
  - hdl/trigger_unit.sv
  - hdl/capture_buffer.sv
  - hdl/scope_trigger_top.sv
  - target: test
    files:
      - testbench/scope_trigger_asserts.sv
      - testbench/tb_scope_trigger.sv

// ==== filelist.f ====
hdl/scope_pkg.sv
hdl/trig_cfg_if.sv
hdl/scope_regs.sv
hdl/trigger_unit.sv
hdl/capture_buffer.sv
hdl/scope_trigger_top.sv
testbench/scope_trigger_asserts.sv
testbench/tb_scope_trigger.sv

// ==== hdl/capture_buffer.sv ====
module capture_buffer (
  input  logic                            adc_clk,
  input  logic                            reset,

  input  logic [scope_pkg::sample_w-1:0]  adc_data_i,   // live adc samples
  input  logic                            capture_go_i, // first sample this cycle

  // readout stream
  input  logic                            samp_ready_i,
  output logic                            samp_valid_o,
  output logic [scope_pkg::sample_w-1:0]  samp_data_o,

  output logic                            capture_done_o // final transfer accepted
);

  // sample store
  logic [scope_pkg::sample_w-1:0]  mem [scope_pkg::capture_depth];

  logic [scope_pkg::ptr_w-1:0]     wr_ptr;   // next write slot
  logic [scope_pkg::ptr_w-1:0]     rd_ptr;   // slot on the stream
  logic                            filling;  // storing one sample per cycle
  logic                            draining; // streaming out
  logic                            idle;
  logic                            start;    // go seen while idle
  logic                            wr_en;
  logic                            xfer;     // handshake this edge
  logic                            last_wr;
  logic                            last_rd;

  assign idle    = ~filling & ~draining;
  assign start   = idle & capture_go_i;   // go while busy is dropped
  assign wr_en   = start | filling;
  assign last_wr = filling & (wr_ptr == scope_pkg::last_ptr);
  assign xfer    = samp_valid_o & samp_ready_i;
  assign last_rd = (rd_ptr == scope_pkg::last_ptr);

  // memory write
  always_ff @(posedge adc_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= adc_data_i;
    end
  end

  // write side
  always_ff @(posedge adc_clk) begin
    if (reset) begin
      wr_ptr  <= '0;
      filling <= 1'b0;
    end else if (start) begin
      wr_ptr  <= wr_ptr + 1'b1; // slot 0 taken now
      filling <= 1'b1;
    end else if (last_wr) begin
      wr_ptr  <= '0;
      filling <= 1'b0;
    end else if (filling) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  // read side starts only once full
  always_ff @(posedge adc_clk) begin
    if (reset) begin
      rd_ptr   <= '0;
      draining <= 1'b0;
    end else if (last_wr) begin
      rd_ptr   <= '0;
      draining <= 1'b1;
    end else if (xfer && last_rd) begin
      rd_ptr   <= '0;
      draining <= 1'b0; // back to idle
    end else if (xfer) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // data and valid hold under back-pressure since rd_ptr only moves on xfer
  assign samp_valid_o = draining;
  assign samp_data_o  = mem[rd_ptr];

  // same edge as the final transfer
  assign capture_done_o = xfer & last_rd;

endmodule

// ==== hdl/scope_pkg.sv ====
package scope_pkg;

  // host register port
  localparam int addr_w = 4;   // register address bits
  localparam int data_w = 32;  // host word bits

  // adc side
  localparam int sample_w = 10;      // one adc sample
  localparam int capture_depth = 16; // samples per capture, single segment

  // pointer into the capture memory
  localparam int ptr_w = $clog2(capture_depth);

  // index of the final sample in a capture
  localparam logic [ptr_w-1:0] last_ptr = ptr_w'(capture_depth - 1);

  // register map
  localparam logic [addr_w-1:0] addr_ctrl   = 4'h0; // control flags
  localparam logic [addr_w-1:0] addr_offset = 4'h1; // trigger offset in adc cycles

  // control word layout, arm sits in bit 0
  typedef struct packed {
    logic [27:0] reserved;      // unused, writes ignored
    logic        trigger_wait;  // 1 = see inactive level before arming
    logic        trigger_level; // 1 = high/rising, 0 = low/falling
    logic        trigger_now;   // host sets then clears
    logic        arm;           // edge sensitive, toggle low then high to rearm
  } trig_ctrl_t;

  // one host word, two readings
  // ctrl view when the address is addr_ctrl
  // raw view when the address is addr_offset
  typedef union packed {
    trig_ctrl_t              ctrl;
    logic [data_w-1:0]       raw;
  } host_word_u;

endpackage

// ==== hdl/scope_regs.sv ====
module scope_regs (
  input  logic                          adc_clk,
  input  logic                          reset,

  // host write port
  input  logic                          reg_valid_i,
  input  logic [scope_pkg::addr_w-1:0]  reg_addr_i,
  input  scope_pkg::host_word_u         reg_data_i,
  output logic                          reg_ready_o,

  // decoded config out
  trig_cfg_if.decoder                   cfg
);

  logic                          ready_q;    // low only in reset
  logic                          wr_en;      // host word accepted this edge
  logic                          sel_ctrl;   // address hits control word
  logic                          sel_offset; // address hits offset word

  // stored control flags
  logic                          arm_q;
  logic                          trig_now_q;
  logic                          level_q;
  logic                          wait_q;

  // stored offset count
  logic [scope_pkg::data_w-1:0]  offset_q;

  // address decode
  assign sel_ctrl   = (reg_addr_i == scope_pkg::addr_ctrl);
  assign sel_offset = (reg_addr_i == scope_pkg::addr_offset);
  assign wr_en      = reg_valid_i & ready_q;

  // ready comes up the cycle after reset drops
  always_ff @(posedge adc_clk) begin
    if (reset) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= 1'b1;
    end
  end

  assign reg_ready_o = ready_q;

  // control word through the ctrl view
  always_ff @(posedge adc_clk) begin
    if (reset) begin
      arm_q      <= 1'b0;
      trig_now_q <= 1'b0;
      level_q    <= 1'b0;
      wait_q     <= 1'b0;
    end else if (wr_en && sel_ctrl) begin
      arm_q      <= reg_data_i.ctrl.arm;
      trig_now_q <= reg_data_i.ctrl.trigger_now; // level request, host clears it
      level_q    <= reg_data_i.ctrl.trigger_level;
      wait_q     <= reg_data_i.ctrl.trigger_wait;
    end
  end

  // offset word through the raw view
  always_ff @(posedge adc_clk) begin
    if (reset) begin
      offset_q <= '0;
    end else if (wr_en && sel_offset) begin
      offset_q <= reg_data_i.raw;
    end
  end

  // other addresses fall through, word taken and dropped

  // visible to the trigger unit one cycle after the write
  assign cfg.arm            = arm_q;
  assign cfg.trigger_now    = trig_now_q;
  assign cfg.trigger_level  = level_q;
  assign cfg.trigger_wait   = wait_q;
  assign cfg.trigger_offset = offset_q;

endmodule

// ==== hdl/scope_trigger_top.sv ====
module scope_trigger_top (
  input  logic                            adc_clk,
  input  logic                            reset,

  // host register writes
  input  logic                            reg_valid_i,
  input  logic [scope_pkg::addr_w-1:0]    reg_addr_i,
  input  logic [scope_pkg::data_w-1:0]    reg_data_i,
  output logic                            reg_ready_o,

  // front end
  input  logic                            trigger_i,
  input  logic [scope_pkg::sample_w-1:0]  adc_data_i,

  // status
  output logic                            arm_o,
  output logic                            capture_active_o,
  output logic [31:0]                     trigger_length_o,

  // sample stream
  output logic                            samp_valid_o,
  output logic [scope_pkg::sample_w-1:0]  samp_data_o,
  input  logic                            samp_ready_i
);

  logic capture_go;   // trigger to buffer
  logic capture_done; // buffer back to trigger

  trig_cfg_if cfg_if ();

  scope_regs u_scope_regs (
    .adc_clk     (adc_clk),
    .reset       (reset),
    .reg_valid_i (reg_valid_i),
    .reg_addr_i  (reg_addr_i),
    .reg_data_i  (reg_data_i), // raw bits, union view picked inside
    .reg_ready_o (reg_ready_o),
    .cfg         (cfg_if.decoder)
  );

  trigger_unit u_trigger_unit (
    .adc_clk          (adc_clk),
    .reset            (reset),
    .trigger_i        (trigger_i),
    .cfg              (cfg_if.trigger),
    .capture_done_i   (capture_done),
    .arm_o            (arm_o),
    .capture_active_o (capture_active_o),
    .capture_go_o     (capture_go),
    .trigger_length_o (trigger_length_o)
  );

  capture_buffer u_capture_buffer (
    .adc_clk        (adc_clk),
    .reset          (reset),
    .adc_data_i     (adc_data_i),
    .capture_go_i   (capture_go),
    .samp_ready_i   (samp_ready_i),
    .samp_valid_o   (samp_valid_o),
    .samp_data_o    (samp_data_o),
    .capture_done_o (capture_done)
  );

endmodule

// ==== hdl/trig_cfg_if.sv ====
interface trig_cfg_if;

  // decoded trigger setup, all registered in the decoder
  logic                          arm;            // level copy of the arm bit
  logic                          trigger_now;    // raw request, synced downstream
  logic                          trigger_level;  // active level of trigger_i
  logic                          trigger_wait;   // wait for inactive before arming
  logic [scope_pkg::data_w-1:0]  trigger_offset; // cycles from trigger to capture start

  // register side drives
  modport decoder (
    output arm,
    output trigger_now,
    output trigger_level,
    output trigger_wait,
    output trigger_offset
  );

  // execute side only reads
  modport trigger (
    input arm,
    input trigger_now,
    input trigger_level,
    input trigger_wait,
    input trigger_offset
  );

endinterface

// ==== hdl/trigger_unit.sv ====
module trigger_unit (
  input  logic                          adc_clk,
  input  logic                          reset,
  input  logic                          trigger_i,        // external trigger, adc_clk aligned

  trig_cfg_if.trigger                   cfg,

  input  logic                          capture_done_i,   // last sample read out
  output logic                          arm_o,            // arm status, ignores conditions
  output logic                          capture_active_o, // high from trigger to done
  output logic                          capture_go_o,     // one cycle, starts storage
  output logic [31:0]                   trigger_length_o  // cycles spent at active level
);

  logic                          arm_dly;          // last cycle's arm bit
  logic                          arm_edge;         // arm rising
  logic                          armed;            // ready to accept trigger
  logic                          reset_arm;        // holds off armed after a trigger
  logic                          resetarm;
  logic [1:0]                    now_sync;         // trigger-now synchronizer
  logic                          now_dly;          // for rising edge detect
  logic                          trigger_now;      // one cycle trigger-now pulse
  logic                          at_level;         // trigger_i at active level
  logic                          fire;             // trigger condition this cycle
  logic                          int_reset_capture;
  logic                          capture_go_start; // offset countdown running
  logic                          triggered;        // blocks a second go per trigger
  logic [scope_pkg::data_w-1:0]  delay_cnt;        // offset counter

  assign at_level = (trigger_i == cfg.trigger_level);
  assign arm_edge = cfg.arm & ~arm_dly;

  always_ff @(posedge adc_clk) begin
    if (reset) begin
      arm_dly <= 1'b0;
    end else begin
      arm_dly <= cfg.arm;
    end
  end

  // two flops then edge detect
  always_ff @(posedge adc_clk) begin
    if (reset) begin
      now_sync <= 2'b00;
      now_dly  <= 1'b0;
    end else begin
      now_sync <= {now_sync[0], cfg.trigger_now};
      now_dly  <= now_sync[1];
    end
  end

  assign trigger_now = now_sync[1] & ~now_dly;
  assign fire        = (at_level & armed) | trigger_now;

  // set on trigger, cleared once host drops arm and capture is over
  always_ff @(posedge adc_clk) begin
    if (reset) begin
      reset_arm <= 1'b0;
    end else if (fire) begin
      reset_arm <= 1'b1;
    end else if (!cfg.arm && !capture_active_o) begin
      reset_arm <= 1'b0;
    end
  end

  assign resetarm = reset | reset_arm;

  // with trigger_wait, the inactive level must be seen first
  always_ff @(posedge adc_clk) begin
    if (resetarm) begin
      armed <= 1'b0;
    end else if (cfg.arm && (!at_level || !cfg.trigger_wait)) begin
      armed <= 1'b1;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (resetarm) begin
      arm_o <= 1'b0;
    end else if (cfg.arm) begin
      arm_o <= 1'b1;
    end
  end

  // done, reset or arm low all end the capture
  assign int_reset_capture = capture_done_i | reset | ~cfg.arm;

  always_ff @(posedge adc_clk) begin
    if (int_reset_capture) begin
      capture_active_o <= 1'b0;
      capture_go_start <= 1'b0;
    end else begin
      if (fire)
        capture_active_o <= 1'b1;
      if (((at_level && (capture_active_o || armed)) || trigger_now) && !triggered)
        capture_go_start <= 1'b1;
      else if (capture_go_o)
        capture_go_start <= 1'b0; // countdown finished
    end
  end

  // rearmed for a new go only after trigger leaves its level
  always_ff @(posedge adc_clk) begin
    if (int_reset_capture) begin
      triggered <= 1'b0;
    end else if (capture_go_start) begin
      triggered <= 1'b1;
    end else if (!at_level) begin
      triggered <= 1'b0;
    end
  end

  // offset delay, counter cleared on arm so a stale count never leaks over
  always_ff @(posedge adc_clk) begin
    if (reset || arm_edge) begin
      delay_cnt    <= '0;
      capture_go_o <= 1'b0;
    end else if (capture_go_o) begin
      capture_go_o <= 1'b0; // single cycle pulse
    end else if (capture_go_start && (delay_cnt == cfg.trigger_offset)) begin
      delay_cnt    <= '0;
      capture_go_o <= 1'b1;
    end else if (capture_go_start) begin
      delay_cnt <= delay_cnt + 1'b1;
    end
  end

  // pulse width in adc cycles, multiple toggles just add up
  always_ff @(posedge adc_clk) begin
    if (reset || arm_edge) begin
      trigger_length_o <= '0;
    end else if (at_level) begin
      trigger_length_o <= trigger_length_o + 32'd1;
    end
  end

endmodule

// ==== testbench/scope_trigger_asserts.sv ====
module scope_trigger_asserts (
  input logic                           adc_clk,
  input logic                           reset,
  input logic                           arm_o,
  input logic                           capture_active_o,
  input logic                           samp_valid_o,
  input logic                           samp_ready_i,
  input logic [scope_pkg::sample_w-1:0] samp_data_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // stream frozen while the sink stalls
  stream_hold: assert property (@(posedge adc_clk) disable iff (reset)
    samp_valid_o && !samp_ready_i |=> samp_valid_o && $stable(samp_data_o))
    else $error("samp_valid_o or samp_data_o moved under back-pressure");

  // sync reset clears status and stream
  reset_clear: assert property (@(posedge adc_clk)
    reset |=> !arm_o && !capture_active_o && !samp_valid_o)
    else $error("status or stream not low after reset");

  valid_in_capture: assert property (@(posedge adc_clk) disable iff (reset)
    samp_valid_o |-> capture_active_o)
    else $error("samp_valid_o high outside a capture");

endmodule

bind scope_trigger_top scope_trigger_asserts u_scope_trigger_asserts (
  .adc_clk          (adc_clk),
  .reset            (reset),
  .arm_o            (arm_o),
  .capture_active_o (capture_active_o),
  .samp_valid_o     (samp_valid_o),
  .samp_ready_i     (samp_ready_i),
  .samp_data_o      (samp_data_o)
);

// ==== testbench/tb_scope_trigger.sv ====
module tb_scope_trigger;
  timeunit 1ns;
  timeprecision 100ps;

  typedef logic [scope_pkg::sample_w-1:0] sample_t;

  localparam logic [31:0] lfsr_seed = 32'h1dac;
  localparam logic [31:0] lfsr_taps = 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1
  localparam int capture_len = 100;  // arm, offset, fill and a stalled drain
  localparam int idle_len = 30;      // each hold phase with no capture
  // reset, eight captures, four hold phases and a margin
  localparam int timeout_cycles = 8 + 8 * capture_len + 4 * idle_len + 200;
  localparam int len_hold = 9;       // cycles at level in the length test

  logic                           adc_clk = 1'b0;
  logic                           reset;
  logic                           reg_valid_i;
  logic [scope_pkg::addr_w-1:0]   reg_addr_i;
  logic [scope_pkg::data_w-1:0]   reg_data_i;
  logic                           reg_ready_o;
  logic                           trigger_i;
  logic [scope_pkg::sample_w-1:0] adc_data_i;
  logic                           arm_o;
  logic                           capture_active_o;
  logic [31:0]                    trigger_length_o;
  logic                           samp_valid_o;
  logic [scope_pkg::sample_w-1:0] samp_data_o;
  logic                           samp_ready_i;
  logic [31:0]                    lfsr = lfsr_seed; // ready stall source
  int                             cycles = 0;

  scope_trigger_top u_scope_trigger_top (.*);

  always #4 adc_clk = ~adc_clk; // 8 ns

  // free running adc ramp
  always @(posedge adc_clk) begin
    #1;
    adc_data_i = adc_data_i + 1'b1;
  end

  always @(posedge adc_clk) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
      fail_run("timeout");
    end
  end

  task automatic fail_run(input string why);
    $display("Done: errors found");
    $fatal(1, why);
  endtask

  task automatic check_sample(input logic [scope_pkg::sample_w-1:0] got, exp,
                              input string what);
    if (got !== exp) begin
      $display("Error at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
      fail_run("wrong sample");
    end
  endtask

  task automatic check_length(input logic [31:0] got, exp, input string what);
    if (got !== exp) begin
      $display("Error at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
      fail_run("wrong trigger length");
    end
  endtask

  task automatic check_flag(input logic got, exp, input string what);
    if (got !== exp) begin
      $display("Error at %0t ns: %s got %b expected %b", $time, what, got, exp);
      fail_run("wrong flag");
    end
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1); // galois form
  endfunction

  function automatic logic [31:0] ctrl_word(input logic arm, now, level, wait_first);
    scope_pkg::host_word_u w;
    w.raw                = '0;
    w.ctrl.arm           = arm;
    w.ctrl.trigger_now   = now;
    w.ctrl.trigger_level = level;
    w.ctrl.trigger_wait  = wait_first;
    return w.raw;
  endfunction

  // every task starts and ends 1 ns after a rising edge
  task automatic step();
    @(posedge adc_clk);
    #1;
  endtask

  task automatic write_reg(input logic [scope_pkg::addr_w-1:0] addr, input logic [31:0] data);
    logic rdy;
    reg_valid_i = 1'b1;
    reg_addr_i  = addr;
    reg_data_i  = data;
    do begin
      rdy = reg_ready_o; // seen by the coming edge
      step();
    end while (!rdy);
    reg_valid_i = 1'b0;
  endtask

  // arm low then high and arm_o follows a cycle later
  task automatic arm_scope(input logic level, input logic wait_first);
    write_reg(scope_pkg::addr_ctrl, ctrl_word(1'b0, 1'b0, level, wait_first));
    write_reg(scope_pkg::addr_ctrl, ctrl_word(1'b1, 1'b0, level, wait_first));
    step();
    check_flag(arm_o, 1'b1, "arm_o after arm write");
  endtask

  // ramp value read once it has settled in this cycle
  task automatic drive_trigger(input logic value, output logic [scope_pkg::sample_w-1:0] r);
    trigger_i = value;
    #1 r = adc_data_i;
    step();
  endtask

  task automatic wait_active();
    while (!capture_active_o) step();
  endtask

  task automatic expect_idle(input int n);
    repeat (n) begin
      check_flag(samp_valid_o, 1'b0, "samp_valid_o with no capture");
      check_flag(capture_active_o, 1'b0, "capture_active_o with no capture");
      step();
    end
  endtask

  task automatic collect_capture(input logic [scope_pkg::sample_w-1:0] first,
                                 input logic stall);
    logic [scope_pkg::sample_w-1:0] exp_s;
    int got;
    exp_s = first;
    got = 0;
    while (got < scope_pkg::capture_depth) begin
      check_flag(capture_active_o, 1'b1, "capture_active_o before last transfer");
      if (stall) begin
        lfsr = lfsr_next(lfsr); // one step per ready bit
        samp_ready_i = lfsr[0];
      end else begin
        samp_ready_i = 1'b1;
      end
      if (samp_valid_o && samp_ready_i) begin
        check_sample(samp_data_o, exp_s, "streamed sample");
        exp_s = exp_s + 1'b1;
        got++;
      end
      step();
    end
    samp_ready_i = 1'b0;
    check_flag(capture_active_o, 1'b0, "capture_active_o after capture done");
    check_flag(arm_o, 1'b0, "arm_o after capture done");
  endtask

  task automatic level_capture(input int offset, input logic stall);
    logic [scope_pkg::sample_w-1:0] r;
    trigger_i = 1'b0;
    write_reg(scope_pkg::addr_offset, 32'(offset));
    arm_scope(1'b1, 1'b0);
    drive_trigger(1'b1, r);
    collect_capture(sample_t'(r + offset + 2), stall);
    trigger_i = 1'b0;
  endtask

  task automatic wait_inactive_test();
    logic [scope_pkg::sample_w-1:0] r;
    trigger_i = 1'b1; // active before arming
    write_reg(scope_pkg::addr_offset, 32'd2);
    arm_scope(1'b1, 1'b1);
    expect_idle(12);
    drive_trigger(1'b0, r);
    drive_trigger(1'b1, r);
    collect_capture(sample_t'(r + 4), 1'b0);
    trigger_i = 1'b0;
  endtask

  task automatic trigger_now_test();
    logic [scope_pkg::sample_w-1:0] r;
    trigger_i = 1'b0;
    write_reg(scope_pkg::addr_offset, 32'd0);
    arm_scope(1'b1, 1'b0);
    expect_idle(4);
    write_reg(scope_pkg::addr_ctrl, ctrl_word(1'b1, 1'b1, 1'b1, 1'b0));
    wait_active();
    #1 r = adc_data_i; // ramp in the cycle after the firing edge
    collect_capture(sample_t'(r + 1), 1'b0); // go pulse one cycle on at zero offset
    write_reg(scope_pkg::addr_ctrl, ctrl_word(1'b1, 1'b0, 1'b1, 1'b0)); // host drops request
  endtask

  task automatic rearm_test();
    logic [scope_pkg::sample_w-1:0] r;
    level_capture(1, 1'b0);
    drive_trigger(1'b1, r); // no rearm yet
    expect_idle(idle_len - 6);
    trigger_i = 1'b0;
    write_reg(scope_pkg::addr_ctrl, ctrl_word(1'b1, 1'b0, 1'b1, 1'b0)); // high again without an edge
    drive_trigger(1'b1, r);
    expect_idle(idle_len - 6);
    trigger_i = 1'b0;
    level_capture(1, 1'b0); // low then high works
  endtask

  // active level is a low input
  task automatic length_test();
    logic [scope_pkg::sample_w-1:0] r;
    trigger_i = 1'b1;
    write_reg(scope_pkg::addr_offset, 32'd0);
    arm_scope(1'b0, 1'b0);
    drive_trigger(1'b0, r);
    repeat (len_hold - 1) step();
    trigger_i = 1'b1;
    collect_capture(sample_t'(r + 2), 1'b0);
    check_length(trigger_length_o, 32'(len_hold), "trigger_length_o");
  endtask

  initial begin
    reset        = 1'b1;
    reg_valid_i  = 1'b0;
    reg_addr_i   = '0;
    reg_data_i   = '0;
    trigger_i    = 1'b0;
    adc_data_i   = '0;
    samp_ready_i = 1'b0;
    repeat (8) @(posedge adc_clk);
    #1 reset = 1'b0;
    step();
    check_flag(reg_ready_o, 1'b1, "reg_ready_o out of reset");
    level_capture(0, 1'b0);
    level_capture(5, 1'b0);
    wait_inactive_test();
    trigger_now_test();
    rearm_test();
    length_test();
    level_capture(3, 1'b1); // ready from lfsr
    $display("Done: no errors");
    $finish;
  end

endmodule
